// File: walksat_pkg.sv
/*
 * Shared sizes and types of the WalkSAT variable-pick stage.
 * Sized for 3-SAT with 16 variables, 32 clauses and 8 occurrences per variable.
 * A table load word is 7 bits. The load kind selects its decoding.
 */
`default_nettype none

package walksat_pkg;

    // problem size
    localparam int NSAT        = 3;
    localparam int NUM_VARS    = 16;
    localparam int VAR_BITS    = 4;
    localparam int NUM_CLAUSES = 32;
    localparam int CLAUSE_BITS = 5;
    localparam int MAX_OCC     = 8;
    localparam int OCC_BITS    = 3;
    localparam int BREAK_BITS  = 4;
    // lane index, value NSAT means nothing selected
    localparam int SEL_BITS    = 2;

    // random walk taken below this threshold, roughly 0.43
    localparam logic [31:0] WALK_P = 32'h6E147AE0;

    typedef struct packed {
        logic [VAR_BITS-1:0] var_idx;
        logic                valid;
    } literal_t;

    typedef struct packed {
        literal_t [NSAT-1:0] lits;
        logic [31:0]         random_word;
    } clause_job_t;

    // one entry of a variable's occurrence list
    typedef struct packed {
        logic [CLAUSE_BITS-1:0] clause_idx;
        logic                   sign;
        logic                   valid;
    } occ_entry_t;

    typedef struct packed {
        logic [4:0] pad;
        logic [1:0] count;
    } clause_count_t;

    typedef struct packed {
        logic [5:0] pad;
        logic       value;
    } var_value_t;

    typedef union packed {
        occ_entry_t    occ;
        clause_count_t count;
        var_value_t    var_value;
    } table_word_u;

    typedef enum logic [1:0] {
        LOAD_VAR,
        LOAD_CLAUSE,
        LOAD_OCC
    } load_kind_e;

    typedef struct packed {
        load_kind_e             kind;
        logic [CLAUSE_BITS-1:0] index;
        logic [OCC_BITS-1:0]    slot;
        table_word_u            word;
    } table_load_t;

    typedef struct packed {
        logic [BREAK_BITS-1:0] break_val;
        logic                  valid;
    } lane_result_t;

    typedef struct packed {
        logic [SEL_BITS-1:0]   select;
        logic [VAR_BITS-1:0]   var_idx;
        logic [BREAK_BITS-1:0] break_val;
        logic                  walk;
    } pick_result_t;

endpackage

`default_nettype wire

// File: sat_state_store.sv
/*
 * Solver tables held in flops, cleared by reset.
 * One write per cycle through the load port. Loads must not overlap a job.
 * Each lane gets its own combinational read port.
 */
`timescale 1ns/1ps
`default_nettype none

module sat_state_store (
    input  logic                                                 clk,
    input  logic                                                 arst_n,
    input  logic                                                 load_en,
    input  walksat_pkg::table_load_t                             load,
    input  logic [walksat_pkg::NSAT-1:0][walksat_pkg::VAR_BITS-1:0] lane_var,
    input  logic [walksat_pkg::NSAT-1:0][walksat_pkg::OCC_BITS-1:0] lane_slot,
    output walksat_pkg::occ_entry_t [walksat_pkg::NSAT-1:0]      lane_occ,
    output logic [walksat_pkg::NSAT-1:0]                         lane_value,
    output logic [walksat_pkg::NSAT-1:0][1:0]                    lane_true_count
);

    // current assignment, one bit per variable
    logic [walksat_pkg::NUM_VARS-1:0] assign_q;

    // true-literal count per clause
    logic [walksat_pkg::NUM_CLAUSES-1:0][1:0] count_q;

    // occurrence lists, MAX_OCC slots per variable
    walksat_pkg::occ_entry_t [walksat_pkg::NUM_VARS-1:0][walksat_pkg::MAX_OCC-1:0] occ_q;

    logic [walksat_pkg::VAR_BITS-1:0] load_var;

    // variable loads use the low bits of the shared index
    assign load_var = load.index[walksat_pkg::VAR_BITS-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            assign_q <= '0;
            count_q  <= '0;
            occ_q    <= '0;
        end else if (load_en) begin
            case (load.kind)
                walksat_pkg::LOAD_VAR: begin
                    assign_q[load_var] <= load.word.var_value.value;
                end
                walksat_pkg::LOAD_CLAUSE: begin
                    count_q[load.index] <= load.word.count.count;
                end
                walksat_pkg::LOAD_OCC: begin
                    occ_q[load_var][load.slot] <= load.word.occ;
                end
                default: begin
                    // unused kind, write ignored
                end
            endcase
        end
    end

    // lane reads
    // the true count follows the clause named by the entry just read
    always_comb begin
        for (int i = 0; i < walksat_pkg::NSAT; i++) begin
            lane_occ[i]        = occ_q[lane_var[i]][lane_slot[i]];
            lane_value[i]      = assign_q[lane_var[i]];
            lane_true_count[i] = count_q[lane_occ[i].clause_idx];
        end
    end

endmodule

`default_nettype wire

// File: clause_dispatch.sv
/*
 * Four-phase req/ack front end for one clause job at a time.
 * The job is latched on acceptance, so the requester bus is free afterwards.
 * job_ack holds as long as job_req stays high.
 */
`timescale 1ns/1ps
`default_nettype none

module clause_dispatch (
    input  logic                                    clk,
    input  logic                                    arst_n,
    input  logic                                    job_req,
    input  walksat_pkg::clause_job_t                job,
    output logic                                    job_ack,
    output logic                                    start,
    output walksat_pkg::literal_t [walksat_pkg::NSAT-1:0] lane_lit,
    output logic [31:0]                             random_word,
    input  logic [walksat_pkg::NSAT-1:0]            lane_done,
    output logic                                    eval,
    input  logic                                    pick_valid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SCAN,
        ST_PICK,
        ST_ACK
    } state_e;

    state_e state_q;
    logic   start_q;
    logic   eval_q;
    logic   ack_q;

    walksat_pkg::clause_job_t job_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
            eval_q  <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            eval_q  <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (job_req) begin
                        start_q <= 1'b1;
                        state_q <= ST_SCAN;
                    end
                end
                ST_SCAN: begin
                    // done levels are stale while start is still high
                    if (!start_q && (&lane_done)) begin
                        eval_q  <= 1'b1;
                        state_q <= ST_PICK;
                    end
                end
                ST_PICK: begin
                    if (pick_valid) begin
                        ack_q   <= 1'b1;
                        state_q <= ST_ACK;
                    end
                end
                default: begin
                    if (!job_req) begin
                        ack_q   <= 1'b0;
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // job payload, captured when accepted
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && job_req) begin
            job_q <= job;
        end
    end

    assign start       = start_q;
    assign eval        = eval_q;
    assign job_ack     = ack_q;
    assign lane_lit    = job_q.lits;
    assign random_word = job_q.random_word;

endmodule

`default_nettype wire

// File: break_counter.sv
/*
 * One lane of the break count.
 * Slot 0 is checked in the start cycle and then one slot per cycle.
 * The scan stops at the first invalid entry or after MAX_OCC slots.
 */
`timescale 1ns/1ps
`default_nettype none

module break_counter (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                start,
    input  walksat_pkg::literal_t               lit,
    output logic [walksat_pkg::VAR_BITS-1:0]    var_idx,
    output logic [walksat_pkg::OCC_BITS-1:0]    slot,
    input  walksat_pkg::occ_entry_t             occ,
    input  logic                                value,
    input  logic [1:0]                          true_count,
    output walksat_pkg::lane_result_t           lane,
    output logic                                done
);

    logic                                busy_q;
    logic                                valid_q;
    logic [walksat_pkg::OCC_BITS-1:0]    slot_q;
    logic [walksat_pkg::BREAK_BITS-1:0]  count_q;
    logic                                breaks;
    logic                                last_slot;

    // literal currently true and the only true one in its clause
    assign breaks    = occ.valid && (occ.sign == value) && (true_count == 2'd1);
    assign last_slot = (slot_q == walksat_pkg::OCC_BITS'(walksat_pkg::MAX_OCC - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            slot_q  <= '0;
            count_q <= '0;
        end else if (start) begin
            // slot_q is zero while idle, so slot 0 is already addressed
            valid_q <= lit.valid;
            count_q <= (lit.valid && breaks) ? walksat_pkg::BREAK_BITS'(1) : '0;
            busy_q  <= lit.valid && occ.valid;
            slot_q  <= (lit.valid && occ.valid) ? walksat_pkg::OCC_BITS'(1) : '0;
        end else if (busy_q) begin
            if (breaks) begin
                count_q <= count_q + 1'b1;
            end
            if (!occ.valid || last_slot) begin
                busy_q <= 1'b0;
                slot_q <= '0;
            end else begin
                slot_q <= slot_q + 1'b1;
            end
        end
    end

    assign var_idx        = lit.var_idx;
    assign slot           = slot_q;
    assign lane.break_val = count_q;
    assign lane.valid     = valid_q;
    assign done           = !busy_q;

endmodule

`default_nettype wire

// File: heuristic_selector.sv
/*
 * Flip choice from the lane break values, registered one cycle after eval.
 * Order: zero break, then random walk below WALK_P, then lowest break.
 * The walk start lane is the random word's low SEL_BITS modulo NSAT.
 */
`timescale 1ns/1ps
`default_nettype none

module heuristic_selector (
    input  logic                                                  clk,
    input  logic                                                  arst_n,
    input  logic                                                  eval,
    input  walksat_pkg::lane_result_t [walksat_pkg::NSAT-1:0]     lanes,
    input  logic [walksat_pkg::NSAT-1:0][walksat_pkg::VAR_BITS-1:0] lit_vars,
    input  logic [31:0]                                           random_word,
    output walksat_pkg::pick_result_t                             pick,
    output logic                                                  pick_valid
);

    logic                                any_valid;
    logic                                zero_hit;
    logic                                walk_hit;
    logic                                walk_en;
    logic [walksat_pkg::SEL_BITS-1:0]    zero_sel;
    logic [walksat_pkg::SEL_BITS-1:0]    walk_sel;
    logic [walksat_pkg::SEL_BITS-1:0]    walk_start;
    logic [walksat_pkg::SEL_BITS-1:0]    greedy_sel;
    logic [walksat_pkg::BREAK_BITS-1:0]  greedy_break;
    walksat_pkg::pick_result_t           next_pick;
    walksat_pkg::pick_result_t           pick_q;
    logic                                pick_valid_q;

    assign walk_en    = (random_word < walksat_pkg::WALK_P);
    assign walk_start = walksat_pkg::SEL_BITS'(
        random_word[walksat_pkg::SEL_BITS-1:0] % walksat_pkg::NSAT);

    // zero override and greedy minimum in one pass
    // ascending order with <= lets the higher lane win a tie
    always_comb begin
        zero_hit     = 1'b0;
        zero_sel     = '0;
        any_valid    = 1'b0;
        greedy_sel   = '0;
        greedy_break = '0;
        for (int i = 0; i < walksat_pkg::NSAT; i++) begin
            if (lanes[i].valid) begin
                if (lanes[i].break_val == '0) begin
                    zero_hit = 1'b1;
                    zero_sel = walksat_pkg::SEL_BITS'(i);
                end
                if (!any_valid || lanes[i].break_val <= greedy_break) begin
                    greedy_sel   = walksat_pkg::SEL_BITS'(i);
                    greedy_break = lanes[i].break_val;
                end
                any_valid = 1'b1;
            end
        end
    end

    // first valid lane at or after the walk start, wrapping around
    always_comb begin
        int idx;
        walk_hit = 1'b0;
        walk_sel = '0;
        for (int k = 0; k < walksat_pkg::NSAT; k++) begin
            idx = (int'(walk_start) + k) % walksat_pkg::NSAT;
            if (!walk_hit && lanes[idx].valid) begin
                walk_hit = 1'b1;
                walk_sel = walksat_pkg::SEL_BITS'(idx);
            end
        end
    end

    always_comb begin
        next_pick = '0;
        if (!any_valid) begin
            next_pick.select = walksat_pkg::SEL_BITS'(walksat_pkg::NSAT);
        end else begin
            if (zero_hit) begin
                next_pick.select = zero_sel;
            end else if (walk_en && walk_hit) begin
                next_pick.select = walk_sel;
                next_pick.walk   = 1'b1;
            end else begin
                next_pick.select = greedy_sel;
            end
            next_pick.var_idx   = lit_vars[next_pick.select];
            next_pick.break_val = lanes[next_pick.select].break_val;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pick_q       <= '0;
            pick_valid_q <= 1'b0;
        end else begin
            pick_valid_q <= eval;
            if (eval) begin
                pick_q <= next_pick;
            end
        end
    end

    assign pick       = pick_q;
    assign pick_valid = pick_valid_q;

endmodule

`default_nettype wire

// File: walksat_flip_picker.sv
/*
 * WalkSAT variable-pick stage: table store, job front end,
 * NSAT break-count lanes and the heuristic selector.
 * Table loads are only legal while no job is in progress.
 */
`timescale 1ns/1ps
`default_nettype none

module walksat_flip_picker (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      job_req,
    output logic                      job_ack,
    input  walksat_pkg::clause_job_t  job,
    output walksat_pkg::pick_result_t result,
    input  logic                      load_en,
    input  walksat_pkg::table_load_t  load
);

    logic                                                    start;
    logic                                                    eval;
    logic                                                    pick_valid;
    logic [31:0]                                             random_word;
    walksat_pkg::literal_t [walksat_pkg::NSAT-1:0]           lane_lit;
    logic [walksat_pkg::NSAT-1:0][walksat_pkg::VAR_BITS-1:0] lane_var;
    logic [walksat_pkg::NSAT-1:0][walksat_pkg::OCC_BITS-1:0] lane_slot;
    walksat_pkg::occ_entry_t [walksat_pkg::NSAT-1:0]         lane_occ;
    logic [walksat_pkg::NSAT-1:0]                            lane_value;
    logic [walksat_pkg::NSAT-1:0][1:0]                       lane_true_count;
    walksat_pkg::lane_result_t [walksat_pkg::NSAT-1:0]       lane_res;
    logic [walksat_pkg::NSAT-1:0]                            lane_done;

    sat_state_store u_store (
        .clk             (clk),
        .arst_n          (arst_n),
        .load_en         (load_en),
        .load            (load),
        .lane_var        (lane_var),
        .lane_slot       (lane_slot),
        .lane_occ        (lane_occ),
        .lane_value      (lane_value),
        .lane_true_count (lane_true_count)
    );

    clause_dispatch u_dispatch (
        .clk         (clk),
        .arst_n      (arst_n),
        .job_req     (job_req),
        .job         (job),
        .job_ack     (job_ack),
        .start       (start),
        .lane_lit    (lane_lit),
        .random_word (random_word),
        .lane_done   (lane_done),
        .eval        (eval),
        .pick_valid  (pick_valid)
    );

    // one break counter per literal
    for (genvar g = 0; g < walksat_pkg::NSAT; g++) begin : g_lane
        break_counter u_lane (
            .clk        (clk),
            .arst_n     (arst_n),
            .start      (start),
            .lit        (lane_lit[g]),
            .var_idx    (lane_var[g]),
            .slot       (lane_slot[g]),
            .occ        (lane_occ[g]),
            .value      (lane_value[g]),
            .true_count (lane_true_count[g]),
            .lane       (lane_res[g]),
            .done       (lane_done[g])
        );
    end

    // lane variable indices double as the selector's candidate list
    heuristic_selector u_selector (
        .clk         (clk),
        .arst_n      (arst_n),
        .eval        (eval),
        .lanes       (lane_res),
        .lit_vars    (lane_var),
        .random_word (random_word),
        .pick        (result),
        .pick_valid  (pick_valid)
    );

endmodule

`default_nettype wire

// File: tb_walksat_flip_picker.sv
/*
 * Directed testbench for the WalkSAT flip picker.
 * Keeps its own copy of the solver tables and derives each pick from it.
 * Inputs change 10 ns after the rising edge. Loads never overlap a job.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_walksat_flip_picker;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;
    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 20;
    localparam int JOB_CYCLES   = walksat_pkg::MAX_OCC + 10;

    // run length that sizes the watchdog
    localparam int DIRECTED_JOBS   = 18;
    localparam int RANDOM_JOBS     = 8;
    localparam int RELOADS         = 2;
    localparam int DIRECTED_WRITES = 10 * (walksat_pkg::MAX_OCC + 1) + 2;
    localparam int RELOAD_WRITES   =
        walksat_pkg::NUM_VARS * (walksat_pkg::MAX_OCC + 1) + walksat_pkg::NUM_CLAUSES;
    localparam int LIMIT_CYCLES    =
        (DIRECTED_JOBS + RELOADS * RANDOM_JOBS) * JOB_CYCLES + HOLD_CYCLES
        + DIRECTED_WRITES + RELOADS * RELOAD_WRITES + RESET_CYCLES + 10;

    logic clk = 1'b0;
    logic arst_n;
    logic job_req;
    logic job_ack;
    logic load_en;
    walksat_pkg::clause_job_t  job;
    walksat_pkg::pick_result_t result;
    walksat_pkg::table_load_t  load;

    integer seed;
    int     errors;
    int     checks;

    // reference copy of the tables
    walksat_pkg::occ_entry_t m_occ [walksat_pkg::NUM_VARS][walksat_pkg::MAX_OCC];
    logic                    m_value [walksat_pkg::NUM_VARS];
    logic [1:0]              m_count [walksat_pkg::NUM_CLAUSES];

    walksat_flip_picker dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .job_req (job_req),
        .job_ack (job_ack),
        .job     (job),
        .result  (result),
        .load_en (load_en),
        .load    (load)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_pick(input string name, input walksat_pkg::pick_result_t got,
                              input walksat_pkg::pick_result_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $write("ERR t=%0t %s got sel=%0d var=%0d brk=%0d walk=%0b",
                   $time, name, got.select, got.var_idx, got.break_val, got.walk);
            $display(" exp sel=%0d var=%0d brk=%0d walk=%0b",
                     exp.select, exp.var_idx, exp.break_val, exp.walk);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: pass", name);
        end else begin
            $display("%s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic clear_model();
        for (int v = 0; v < walksat_pkg::NUM_VARS; v++) begin
            m_value[v] = 1'b0;
            for (int s = 0; s < walksat_pkg::MAX_OCC; s++) begin
                m_occ[v][s] = '0;
            end
        end
        for (int c = 0; c < walksat_pkg::NUM_CLAUSES; c++) begin
            m_count[c] = 2'd0;
        end
    endtask

    // one table write per cycle
    task automatic write_table(input walksat_pkg::table_load_t w);
        load    = w;
        load_en = 1'b1;
        step();
        load_en = 1'b0;
    endtask

    task automatic write_var(input int v, input logic val);
        walksat_pkg::table_load_t w;
        w = '0;
        w.kind = walksat_pkg::LOAD_VAR;
        w.index = walksat_pkg::CLAUSE_BITS'(v);
        w.word.var_value.value = val;
        m_value[v] = val;
        write_table(w);
    endtask

    task automatic write_clause(input int c, input logic [1:0] cnt);
        walksat_pkg::table_load_t w;
        w = '0;
        w.kind = walksat_pkg::LOAD_CLAUSE;
        w.index = walksat_pkg::CLAUSE_BITS'(c);
        w.word.count.count = cnt;
        m_count[c] = cnt;
        write_table(w);
    endtask

    task automatic write_occ(input int v, input int s, input walksat_pkg::occ_entry_t e);
        walksat_pkg::table_load_t w;
        w = '0;
        w.kind = walksat_pkg::LOAD_OCC;
        w.index = walksat_pkg::CLAUSE_BITS'(v);
        w.slot = walksat_pkg::OCC_BITS'(s);
        w.word.occ = e;
        m_occ[v][s] = e;
        write_table(w);
    endtask

    // clause 0 holds one true literal and clause 1 holds two
    // nbrk breaking entries followed by nsafe entries that do not break
    task automatic build_var(input int v, input logic val, input int nbrk, input int nsafe);
        walksat_pkg::occ_entry_t e;
        write_var(v, val);
        for (int s = 0; s < walksat_pkg::MAX_OCC; s++) begin
            e = '0;
            if (s < nbrk) begin
                e.clause_idx = 5'd0;
                e.sign = val;
                e.valid = 1'b1;
                write_occ(v, s, e);
            end else if (s < nbrk + nsafe) begin
                // alternate a two-true clause and a false literal
                e.clause_idx = ((s - nbrk) % 2 == 0) ? 5'd1 : 5'd0;
                e.sign = ((s - nbrk) % 2 == 0) ? val : !val;
                e.valid = 1'b1;
                write_occ(v, s, e);
            end else if (s == nbrk + nsafe) begin
                write_occ(v, s, e);
            end
        end
    endtask

    function automatic int break_of(input walksat_pkg::literal_t lit);
        int n;
        bit stop;
        walksat_pkg::occ_entry_t e;
        n = 0;
        stop = 1'b0;
        if (lit.valid) begin
            for (int s = 0; s < walksat_pkg::MAX_OCC; s++) begin
                e = m_occ[lit.var_idx][s];
                if (!e.valid) begin
                    stop = 1'b1;
                end
                if (!stop && e.sign == m_value[lit.var_idx]
                    && m_count[e.clause_idx] == 2'd1) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    function automatic walksat_pkg::pick_result_t expected_pick(
        input walksat_pkg::clause_job_t j);
        int brk [walksat_pkg::NSAT];
        int sel;
        int first;
        int idx;
        bit any;
        walksat_pkg::pick_result_t r;
        r = '0;
        sel = -1;
        any = 1'b0;
        for (int i = 0; i < walksat_pkg::NSAT; i++) begin
            brk[i] = break_of(j.lits[i]);
            if (j.lits[i].valid) begin
                any = 1'b1;
                // later zero lanes replace earlier ones
                if (brk[i] == 0) begin
                    sel = i;
                end
            end
        end
        if (!any) begin
            r.select = walksat_pkg::SEL_BITS'(walksat_pkg::NSAT);
            return r;
        end
        if (sel < 0 && j.random_word < walksat_pkg::WALK_P) begin
            first = int'(j.random_word[walksat_pkg::SEL_BITS-1:0]) % walksat_pkg::NSAT;
            // walking backwards leaves the nearest valid lane last
            for (int k = walksat_pkg::NSAT - 1; k >= 0; k--) begin
                idx = (first + k) % walksat_pkg::NSAT;
                if (j.lits[idx].valid) begin
                    sel = idx;
                end
            end
            r.walk = 1'b1;
        end
        if (sel < 0) begin
            for (int i = walksat_pkg::NSAT - 1; i >= 0; i--) begin
                if (j.lits[i].valid && (sel < 0 || brk[i] < brk[sel])) begin
                    sel = i;
                end
            end
        end
        r.select = walksat_pkg::SEL_BITS'(sel);
        r.var_idx = j.lits[sel].var_idx;
        r.break_val = walksat_pkg::BREAK_BITS'(brk[sel]);
        return r;
    endfunction

    function automatic walksat_pkg::clause_job_t make_job(input int v0, input int v1,
        input int v2, input logic [2:0] valid, input logic [31:0] rw);
        walksat_pkg::clause_job_t j;
        j.lits[0].var_idx = walksat_pkg::VAR_BITS'(v0);
        j.lits[1].var_idx = walksat_pkg::VAR_BITS'(v1);
        j.lits[2].var_idx = walksat_pkg::VAR_BITS'(v2);
        j.lits[0].valid = valid[0];
        j.lits[1].valid = valid[1];
        j.lits[2].valid = valid[2];
        j.random_word = rw;
        return j;
    endfunction

    // full four-phase cycle with the result held for hold extra cycles
    task automatic run_job(input walksat_pkg::clause_job_t j, input int hold,
                           output walksat_pkg::pick_result_t r);
        int waited;
        job = j;
        job_req = 1'b1;
        waited = 0;
        while (job_ack !== 1'b1 && waited <= JOB_CYCLES) begin
            step();
            waited++;
            // job is latched by now, so scramble the bus
            job = ~j;
        end
        if (job_ack !== 1'b1) begin
            errors++;
            $display("job_ack did not rise within %0d cycles at t=%0t", waited, $time);
        end else if (waited < 4 || waited > walksat_pkg::MAX_OCC + 4) begin
            errors++;
            $display("job_ack took %0d cycles, outside the allowed range", waited);
        end
        r = result;
        for (int c = 0; c < hold; c++) begin
            step();
            check_bit("job_ack", job_ack, 1'b1);
            check_pick("result", result, r);
        end
        job_req = 1'b0;
        waited = 0;
        while (job_ack !== 1'b0 && waited < 4) begin
            step();
            waited++;
        end
        if (job_ack !== 1'b0) begin
            errors++;
            $display("job_ack stayed high after job_req fell at t=%0t", $time);
        end else if (waited != 1) begin
            errors++;
            $display("job_ack fell %0d cycles after job_req fell at t=%0t", waited, $time);
        end
    endtask

    task automatic check_job(input walksat_pkg::clause_job_t j);
        walksat_pkg::pick_result_t r;
        run_job(j, 0, r);
        check_pick("result", r, expected_pick(j));
    endtask

    task automatic handshake_and_reset();
        int e0;
        walksat_pkg::pick_result_t r;
        walksat_pkg::clause_job_t j;
        e0 = errors;
        check_bit("job_ack", job_ack, 1'b0);
        // cleared tables give every valid lane break 0
        j = make_job(3, 7, 9, 3'b111, 32'h0000_0005);
        run_job(j, HOLD_CYCLES, r);
        check_pick("result", r, expected_pick(j));
        j = make_job(4, 8, 2, 3'b011, 32'hC000_0000);
        check_job(j);
        report_test("handshake and reset", e0);
    endtask

    task automatic zero_override();
        int e0;
        e0 = errors;
        build_var(1, 1'b1, 2, 1);
        build_var(2, 1'b0, 0, 3);
        build_var(3, 1'b1, 1, 0);
        check_job(make_job(1, 2, 3, 3'b111, 32'h0000_0001));
        check_job(make_job(1, 2, 3, 3'b111, 32'hFFFF_FFFF));
        build_var(3, 1'b0, 0, 2);
        check_job(make_job(2, 1, 3, 3'b111, 32'h0000_0010));
        report_test("zero override", e0);
    endtask

    task automatic random_walk();
        int e0;
        e0 = errors;
        build_var(4, 1'b1, 3, 1);
        build_var(5, 1'b0, 1, 2);
        build_var(6, 1'b1, 2, 0);
        for (int low = 0; low < 4; low++) begin
            check_job(make_job(4, 5, 6, 3'b111, 32'h0000_1000 | low));
        end
        // start lane invalid, so the pick moves on or wraps
        check_job(make_job(4, 5, 6, 3'b101, 32'h2000_0001));
        check_job(make_job(4, 5, 6, 3'b011, 32'h2000_0002));
        report_test("random walk", e0);
    endtask

    task automatic greedy_minimum();
        int e0;
        e0 = errors;
        build_var(10, 1'b0, 2, 1);
        build_var(11, 1'b1, 2, 2);
        build_var(12, 1'b1, 8, 0);
        check_job(make_job(4, 5, 6, 3'b111, walksat_pkg::WALK_P));
        check_job(make_job(10, 11, 4, 3'b111, 32'h8000_0000));
        check_job(make_job(6, 4, 10, 3'b111, 32'hFFFF_FFFF));
        check_job(make_job(12, 4, 12, 3'b111, 32'h7000_0003));
        report_test("greedy minimum", e0);
    endtask

    task automatic literal_validity();
        int e0;
        e0 = errors;
        check_job(make_job(4, 5, 6, 3'b000, 32'h0000_0000));
        check_job(make_job(4, 6, 5, 3'b100, 32'hFFFF_0000));
        check_job(make_job(4, 6, 5, 3'b001, 32'h0000_0002));
        report_test("validity", e0);
    endtask

    // random assignment, true counts and occurrence lists
    task automatic reload_tables();
        int len;
        logic [31:0] rnd;
        walksat_pkg::occ_entry_t e;
        for (int v = 0; v < walksat_pkg::NUM_VARS; v++) begin
            rnd = $random(seed);
            write_var(v, rnd[3]);
        end
        for (int c = 0; c < walksat_pkg::NUM_CLAUSES; c++) begin
            rnd = $random(seed);
            write_clause(c, rnd[5:4]);
        end
        for (int v = 0; v < walksat_pkg::NUM_VARS; v++) begin
            rnd = $random(seed);
            len = int'(rnd[15:8]) % (walksat_pkg::MAX_OCC + 1);
            for (int s = 0; s < walksat_pkg::MAX_OCC; s++) begin
                rnd = $random(seed);
                e.clause_idx = rnd[4:0];
                e.sign = rnd[7];
                e.valid = (s < len);
                if (s <= len) begin
                    write_occ(v, s, e);
                end
            end
        end
    endtask

    task automatic table_reload();
        int e0;
        logic [31:0] lits;
        logic [31:0] rw;
        e0 = errors;
        for (int n = 0; n < RELOADS; n++) begin
            reload_tables();
            for (int k = 0; k < RANDOM_JOBS; k++) begin
                lits = $random(seed);
                rw = $random(seed);
                // even jobs may walk and odd jobs stay greedy
                rw = (k % 2 == 0) ? (rw >> 2) : (rw | 32'h8000_0000);
                check_job(make_job(lits[3:0], lits[7:4], lits[11:8],
                    {lits[13:12] != 2'b00, lits[15:14] != 2'b00, lits[17:16] != 2'b00}, rw));
            end
        end
        report_test("table reload", e0);
    endtask

    initial begin
        seed = 32'h81a0cc1a;
        errors = 0;
        checks = 0;
        arst_n = 1'b0;
        job_req = 1'b0;
        job = '0;
        load_en = 1'b0;
        load = '0;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        arst_n = 1'b1;
        step();
        handshake_and_reset();
        write_clause(0, 2'd1);
        write_clause(1, 2'd2);
        zero_override();
        random_walk();
        greedy_minimum();
        literal_validity();
        table_reload();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
walksat_pkg.sv
sat_state_store.sv
clause_dispatch.sv
break_counter.sv
heuristic_selector.sv
walksat_flip_picker.sv
tb_walksat_flip_picker.sv

// File: Bender.yml
package:
  name: walksat_flip_picker

sources:
  - walksat_pkg.sv
  - sat_state_store.sv
  - clause_dispatch.sv
  - break_counter.sv
  - heuristic_selector.sv
  - walksat_flip_picker.sv
  - target: test
    files:
      - tb_walksat_flip_picker.sv
